//--- build.f
+incdir+.
csr_pkg.sv
csr_except_regs.sv
csr_timer.sv
csr_save_bank.sv
csr_read_mux.sv
csr_top.sv
tb_csr.sv

//--- Makefile
SRCS = build.f csr_defines.svh csr_pkg.sv csr_except_regs.sv csr_timer.sv \
       csr_save_bank.sv csr_read_mux.sv csr_top.sv tb_csr.sv

.PHONY: run clean

run: obj_dir/Vtb_csr
	@out=$$(./obj_dir/Vtb_csr); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

obj_dir/Vtb_csr: $(SRCS)
	verilator --binary --assert --top-module tb_csr -f build.f

clean:
	rm -rf obj_dir

//--- tb_csr.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr
    import csr_pkg::*;
();

    logic         clk;
    logic         rst;
    csr_write_t   wr;
    exc_event_t   exc;
    logic         ertn;
    logic [7:0]   hwi;
    logic         ipi;
    logic         rd_en;
    csr_addr_t    rd_addr;
    bus32_t       rd_data;
    except_view_t ctrl_view;

    int seed;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Reference model state
    crmd_t  m_crmd;
    bus32_t m_prmd, m_ecfg, m_era, m_badv, m_eentry, m_tid, m_tval;
    estat_t m_estat;
    tcfg_t  m_tcfg;
    bus32_t m_save [4];
    logic   m_irq;

    csr_addr_t kept_addrs [15] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
        `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_TID, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR};
    csr_addr_t unmapped [6] = '{14'h2, 14'h8, 14'h34, 14'h43, 14'h45, 14'h3fff};

    logic [5:0] codes [5] = '{`ECODE_ADE, `ECODE_ADE, `ECODE_ALE, `ECODE_TLBR, 6'h0b};
    logic [8:0] subs [5] = '{9'd0, 9'd1, 9'd0, 9'd0, 9'd0};

    csr_top uut (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .exc       (exc),
        .ertn      (ertn),
        .hwi       (hwi),
        .ipi       (ipi),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .ctrl_view (ctrl_view)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout: the run did not finish within 2000 clock cycles");
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Keeps only the bits under mask from the new value
    function automatic bus32_t apply_mask(input bus32_t old_val, input bus32_t new_val,
                                          input bus32_t mask);
        return old_val ^ ((old_val ^ new_val) & mask);
    endfunction

    function automatic bus32_t ref_read(input csr_addr_t addr);
        estat_t e;
        e = m_estat;
        e.is_ti = m_irq;   // Live flag
        case (addr)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return e;
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TID:    return m_tid;
            `CSR_TCFG:   return m_tcfg;
            `CSR_TVAL:   return m_tval;
            default:     return '0;   // TICLR and holes
        endcase
    endfunction

    always @(posedge clk) begin : ref_model
        bus32_t next_tval;
        if (rst) begin
            m_crmd = `CRMD_RESET;
            {m_prmd, m_ecfg, m_era, m_badv, m_eentry, m_tid} = '0;
            m_estat = '0;
            m_tcfg = '0;
            m_tval = `TVAL_RESET;
            m_irq = 1'b0;
            for (int i = 0; i < 4; i++) m_save[i] = '0;
        end else begin
            if (exc.valid) begin
                m_prmd[2:0] = {m_crmd.ie, m_crmd.plv};
                m_crmd.plv = 2'b00;
                m_crmd.ie = 1'b0;
                if (exc.ecode == `ECODE_TLBR) {m_crmd.pg, m_crmd.da} = 2'b01;
                m_era = exc.pc;
                m_estat.ecode = exc.ecode;
                m_estat.esubcode = exc.esubcode;
                if (exc.ecode == `ECODE_ALE || exc.ecode == `ECODE_TLBR) m_badv = exc.addr;
                else if (exc.ecode == `ECODE_ADE && exc.esubcode == '0) m_badv = exc.pc;
            end else if (ertn) begin
                m_crmd.plv = m_prmd[1:0];
                m_crmd.ie = m_prmd[2];
                if (m_estat.ecode == `ECODE_TLBR) {m_crmd.pg, m_crmd.da} = 2'b10;
            end else if (wr.valid) begin
                case (wr.addr)
                    `CSR_CRMD:   m_crmd = apply_mask(m_crmd, wr.data, `CRMD_WMASK);
                    `CSR_PRMD:   m_prmd = apply_mask(m_prmd, wr.data, `PRMD_WMASK);
                    `CSR_ECFG:   m_ecfg = apply_mask(m_ecfg, wr.data, `ECFG_WMASK);
                    `CSR_ESTAT:  m_estat = apply_mask(m_estat, wr.data, `ESTAT_WMASK);
                    `CSR_EENTRY: m_eentry = apply_mask(m_eentry, wr.data, `EENTRY_WMASK);
                    `CSR_ERA:    m_era = wr.data;
                    `CSR_BADV:   m_badv = wr.data;
                    default: ;
                endcase
            end
            m_estat.is_hwi = hwi;
            m_estat.is_ipi = ipi;
            if (wr.valid && wr.addr >= `CSR_SAVE0 && wr.addr <= `CSR_SAVE3)
                m_save[2'(wr.addr - `CSR_SAVE0)] = wr.data;
            if (wr.valid && wr.addr == `CSR_TID) m_tid = wr.data;
            if (wr.valid && wr.addr == `CSR_TCFG) begin
                m_tcfg = wr.data;
                next_tval = {wr.data[31:2], 2'b00};
            end else if (m_tcfg.en && m_tval != '0) begin
                next_tval = m_tval - 32'd1;
            end else if (m_tcfg.en && m_tcfg.periodic) begin
                next_tval = {m_tcfg.initval, 2'b00};
            end else begin
                next_tval = m_tval;
            end
            if (m_tval == 32'd1 && next_tval == '0) m_irq = 1'b1;   // Expiry beats a clear
            else if (wr.valid && wr.addr == `CSR_TICLR && wr.data[0]) m_irq = 1'b0;
            m_tval = next_tval;
        end
    end

    task automatic check_word(input bus32_t got, input bus32_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_crmd(input crmd_t got, input crmd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: CRMD plv %0d ie %b da %b pg %b, expected %0d %b %b %b",
                     $time, got.plv, got.ie, got.da, got.pg, exp.plv, exp.ie, exp.da, exp.pg);
        end
    endtask

    task automatic check_estat(input estat_t got, input estat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: ESTAT ecode %h sub %h is %h, expected ecode %h sub %h is %h",
                     $time, got.ecode, got.esubcode, got[12:0],
                     exp.ecode, exp.esubcode, exp[12:0]);
        end
    endtask

    // Compare every read against the model mid-cycle
    always @(negedge clk) begin : compare_reads
        bus32_t exp;
        if (!rst) begin
            exp = rd_en ? ref_read(rd_addr) : '0;
            if (rd_en && rd_addr == `CSR_CRMD) check_crmd(rd_data, exp);
            else if (rd_en && rd_addr == `CSR_ESTAT) check_estat(rd_data, exp);
            else check_word(rd_data, exp, $sformatf("read of %h (en %b)", rd_addr, rd_en));
        end
    end

    task automatic tick;
        @(posedge clk);
        #1;
        wr.valid = 1'b0;
        exc.valid = 1'b0;
        ertn = 1'b0;
    endtask

    task automatic write_csr(input csr_addr_t addr, input bus32_t data);
        wr = '{1'b1, addr, data};
        tick;
    endtask

    task automatic read_csr(input csr_addr_t addr);
        rd_en = 1'b1;
        rd_addr = addr;
        tick;
    endtask

    task automatic raise_exc(input logic [5:0] ecode, input logic [8:0] sub);
        exc = '{1'b1, ecode, sub, bus32_t'($random(seed)), bus32_t'($random(seed))};
        tick;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    task automatic run_timer(input logic periodic, input logic [29:0] initval);
        write_csr(`CSR_TCFG, {initval, periodic, 1'b1});
        rd_en = 1'b1;
        rd_addr = `CSR_TVAL;
        while (!ctrl_view.estat.is_ti) tick;
        check_word(rd_data, '0, "TVAL at expiry");
        tick;
        check_word(rd_data, periodic ? {initval, 2'b00} : '0, "TVAL after expiry");
        repeat (3) tick;
        write_csr(`CSR_TICLR, 32'h1);
        check_word(32'(ctrl_view.estat.is_ti), '0, "is_ti after TICLR");
        read_csr(`CSR_ESTAT);
        read_csr(`CSR_TICLR);
        write_csr(`CSR_TCFG, '0);
        write_csr(`CSR_TICLR, 32'h1);
    endtask

    initial begin
        int start;
        logic [7:0] hwi_now;
        logic       ipi_now;
        seed = 54970;
        rst = 1'b1;
        wr = '0;
        exc = '0;
        ertn = 1'b0;
        hwi = '0;
        ipi = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        start = errors;
        foreach (kept_addrs[i]) read_csr(kept_addrs[i]);
        foreach (kept_addrs[i]) begin
            write_csr(kept_addrs[i], $random(seed));
            read_csr(kept_addrs[i]);
        end
        write_csr(`CSR_TCFG, '0);
        write_csr(`CSR_TICLR, 32'h1);
        end_test("reset values and masked writes", start);

        start = errors;
        foreach (codes[i]) begin
            write_csr(`CSR_CRMD, 32'h7);   // PLV 3, IE on, DA off
            raise_exc(codes[i], subs[i]);
            read_csr(`CSR_CRMD);
            read_csr(`CSR_PRMD);
            read_csr(`CSR_ERA);
            read_csr(`CSR_ESTAT);
            read_csr(`CSR_BADV);
        end
        end_test("exception entry", start);

        start = errors;
        for (int k = 0; k < 2; k++) begin
            write_csr(`CSR_CRMD, $random(seed));
            raise_exc(k == 1 ? `ECODE_TLBR : 6'h0b, '0);
            write_csr(`CSR_PRMD, $random(seed));
            ertn = 1'b1;
            tick;
            read_csr(`CSR_CRMD);
            read_csr(`CSR_PRMD);
        end
        end_test("exception return", start);

        start = errors;
        run_timer(1'b0, 30'd3);
        run_timer(1'b1, 30'd2);
        end_test("timer one-shot and periodic", start);

        start = errors;
        rd_en = 1'b1;
        rd_addr = `CSR_ESTAT;
        repeat (8) begin
            hwi_now = 8'($random(seed));
            ipi_now = 1'($random(seed));
            hwi = hwi_now;
            ipi = ipi_now;
            tick;
            check_word(32'(ctrl_view.estat.is_hwi), 32'(hwi_now), "sampled hwi");
            check_word(32'(ctrl_view.estat.is_ipi), 32'(ipi_now), "sampled ipi");
        end
        write_csr(`CSR_ESTAT, 32'hffff_ffff);
        read_csr(`CSR_ESTAT);
        write_csr(`CSR_ESTAT, '0);
        hwi = '0;
        ipi = 1'b0;
        read_csr(`CSR_ESTAT);
        end_test("interrupt sampling", start);

        start = errors;
        for (int i = 0; i < 4; i++) write_csr(`CSR_SAVE0 + 14'(i), $random(seed));
        for (int i = 0; i < 4; i++) read_csr(`CSR_SAVE0 + 14'(i));
        foreach (unmapped[i]) read_csr(unmapped[i]);
        rd_addr = `CSR_CRMD;
        rd_en = 1'b0;
        tick;
        check_word(rd_data, '0, "read with rd_en low");
        tick;
        end_test("save bank and unmapped reads", start);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- csr_top.sv
`timescale 1ns/1ps

module csr_top
    import csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  csr_write_t   wr,
    input  exc_event_t   exc,
    input  logic         ertn,
    input  logic [7:0]   hwi,
    input  logic         ipi,
    input  logic         rd_en,
    input  csr_addr_t    rd_addr,
    output bus32_t       rd_data,
    output except_view_t ctrl_view
);

    timer_view_t timer_view;
    bus32_t      save [4];
    logic        timer_irq;

    // Each register module decodes its own addresses from the shared write port
    csr_except_regs u_except_regs (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .exc       (exc),
        .ertn      (ertn),
        .hwi       (hwi),
        .ipi       (ipi),
        .timer_irq (timer_irq),
        .view      (ctrl_view)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .view      (timer_view),
        .timer_irq (timer_irq)
    );

    csr_save_bank u_save_bank (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .save (save)
    );

    csr_read_mux u_read_mux (
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .except_view (ctrl_view),
        .timer_view  (timer_view),
        .save        (save),
        .rd_data     (rd_data)
    );

endmodule

//--- csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_read_mux
    import csr_pkg::*;
(
    input  logic         rd_en,
    input  csr_addr_t    rd_addr,
    input  except_view_t except_view,
    input  timer_view_t  timer_view,
    input  bus32_t       save [4],
    output bus32_t       rd_data
);

    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (rd_addr)
                `CSR_CRMD:   rd_data = except_view.crmd;
                `CSR_PRMD:   rd_data = except_view.prmd;
                `CSR_ECFG:   rd_data = except_view.ecfg;
                `CSR_ESTAT:  rd_data = except_view.estat;
                `CSR_ERA:    rd_data = except_view.era;
                `CSR_BADV:   rd_data = except_view.badv;
                `CSR_EENTRY: rd_data = except_view.eentry;
                `CSR_SAVE0:  rd_data = save[0];
                `CSR_SAVE1:  rd_data = save[1];
                `CSR_SAVE2:  rd_data = save[2];
                `CSR_SAVE3:  rd_data = save[3];
                `CSR_TID:    rd_data = timer_view.tid;
                `CSR_TCFG:   rd_data = timer_view.tcfg;
                `CSR_TVAL:   rd_data = timer_view.tval;
                `CSR_TICLR:  rd_data = '0;   // Clear strobe only
                default:     rd_data = '0;
            endcase
        end
    end

    // CRMD known means reset has run, so every register behind the mux is known
    always_comb begin
        if (rd_en === 1'b1 && !$isunknown(except_view.crmd)) begin
            a_rd_known: assert final (!$isunknown(rd_data))
                else $error("read data unknown at address %h", rd_addr);
        end
    end

endmodule

//--- csr_save_bank.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_save_bank
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    output bus32_t     save [4]
);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (wr.valid) begin
            // SAVE0..3 sit at consecutive addresses
            for (int i = 0; i < 4; i++) begin
                if (wr.addr == `CSR_SAVE0 + 14'(i)) begin
                    save[i] <= wr.data;
                end
            end
        end
    end

endmodule

//--- csr_timer.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr,
    output timer_view_t view,
    output logic        timer_irq
);

    bus32_t tid_q;
    tcfg_t  tcfg_q;
    bus32_t tval_q;
    logic   tcfg_wr;
    logic   ticlr_wr;
    logic   irq_set;

    assign tcfg_wr  = wr.valid && wr.addr == `CSR_TCFG;
    assign ticlr_wr = wr.valid && wr.addr == `CSR_TICLR && wr.data[0];
    assign irq_set  = !tcfg_wr && tcfg_q.en && tval_q == 32'd1;   // Last tick

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q  <= '0;
            tcfg_q <= '0;
            tval_q <= `TVAL_RESET;
        end else begin
            if (wr.valid && wr.addr == `CSR_TID) tid_q <= wr.data;
            if (tcfg_wr) begin
                tcfg_q <= wr.data;
                tval_q <= {wr.data[31:2], 2'b00};
            end else if (tcfg_q.en) begin
                if (tval_q != '0) begin
                    tval_q <= tval_q - 32'd1;
                end else if (tcfg_q.periodic) begin
                    tval_q <= {tcfg_q.initval, 2'b00};
                end
            end
        end
    end

    // Sticky until TICLR, a new expiry wins over the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq <= 1'b0;
        end else if (irq_set) begin
            timer_irq <= 1'b1;
        end else if (ticlr_wr) begin
            timer_irq <= 1'b0;
        end
    end

    assign view = '{tid_q, tcfg_q, tval_q};

    a_tval_no_rise: assert property (@(posedge clk) disable iff (rst)
        (tcfg_q.en && !tcfg_wr) |=>
            (tval_q <= $past(tval_q)) || ($past(tval_q) == '0 && $past(tcfg_q.periodic)))
        else $error("TVAL rose outside a periodic reload");

endmodule

//--- csr_except_regs.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_except_regs
    import csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  csr_write_t   wr,
    input  exc_event_t   exc,
    input  logic         ertn,
    input  logic [7:0]   hwi,
    input  logic         ipi,
    input  logic         timer_irq,
    output except_view_t view
);

    crmd_t  crmd_q;
    bus32_t prmd_q;
    bus32_t ecfg_q;
    estat_t estat_q;
    estat_t estat_d;
    bus32_t era_q;
    bus32_t badv_q;
    bus32_t eentry_q;
    logic   sw_wr;
    logic   exc_tlbr;

    function automatic bus32_t merge(input bus32_t old_val, input bus32_t new_val,
                                     input bus32_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    assign sw_wr    = wr.valid && !exc.valid && !ertn;   // Lowest priority
    assign exc_tlbr = exc.ecode == `ECODE_TLBR;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= `CRMD_RESET;
            prmd_q <= '0;
        end else if (exc.valid) begin
            prmd_q[1:0] <= crmd_q.plv;
            prmd_q[2]   <= crmd_q.ie;
            crmd_q.plv  <= 2'b00;
            crmd_q.ie   <= 1'b0;
            if (exc_tlbr) begin
                crmd_q.da <= 1'b1;   // Refill handler runs untranslated
                crmd_q.pg <= 1'b0;
            end
        end else if (ertn) begin
            crmd_q.plv <= prmd_q[1:0];
            crmd_q.ie  <= prmd_q[2];
            if (estat_q.ecode == `ECODE_TLBR) begin
                crmd_q.da <= 1'b0;
                crmd_q.pg <= 1'b1;
            end
        end else if (sw_wr) begin
            if (wr.addr == `CSR_CRMD) crmd_q <= merge(crmd_q, wr.data, `CRMD_WMASK);
            if (wr.addr == `CSR_PRMD) prmd_q <= merge(prmd_q, wr.data, `PRMD_WMASK);
        end
    end

    // Interrupt lines sampled every cycle, is_ti added on the read side
    always_comb begin
        estat_d = estat_q;
        if (exc.valid) begin
            estat_d.ecode    = exc.ecode;
            estat_d.esubcode = exc.esubcode;
        end else if (sw_wr && wr.addr == `CSR_ESTAT) begin
            estat_d = merge(estat_q, wr.data, `ESTAT_WMASK);
        end
        estat_d.is_hwi = hwi;
        estat_d.is_ipi = ipi;
        estat_d.is_ti  = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_q  <= '0;
            ecfg_q   <= '0;
            eentry_q <= '0;
            era_q    <= '0;
            badv_q   <= '0;
        end else begin
            estat_q <= estat_d;
            if (exc.valid) begin
                era_q <= exc.pc;
                if (exc.ecode == `ECODE_ALE || exc_tlbr) begin
                    badv_q <= exc.addr;
                end else if (exc.ecode == `ECODE_ADE && exc.esubcode == 9'd0) begin
                    badv_q <= exc.pc;   // Fetch address error
                end
            end else if (sw_wr) begin
                case (wr.addr)
                    `CSR_ECFG:   ecfg_q   <= merge(ecfg_q, wr.data, `ECFG_WMASK);
                    `CSR_EENTRY: eentry_q <= merge(eentry_q, wr.data, `EENTRY_WMASK);
                    `CSR_ERA:    era_q    <= wr.data;
                    `CSR_BADV:   badv_q   <= wr.data;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        view        = '{crmd_q, prmd_q, ecfg_q, estat_q, era_q, badv_q, eentry_q};
        view.estat.is_ti = timer_irq;
    end

    // Pipeline never retires ertn alongside a trapping instruction
    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (rst) !(exc.valid && ertn))
        else $error("exception entry and ertn in the same cycle");

endmodule

//--- csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [13:0] csr_addr_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        bus32_t    data;
    } csr_write_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] ecode;
        logic [8:0] esubcode;
        bus32_t     pc;
        bus32_t     addr;     // Faulting data address
    } exc_event_t;

    typedef struct packed {
        logic [22:0] reserved;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    // Field names of the reserved gaps carry their bit position
    typedef struct packed {
        logic        rsv31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  rsv15_13;
        logic        is_ipi;
        logic        is_ti;
        logic        rsv10;
        logic [7:0]  is_hwi;
        logic [1:0]  is_swi;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        crmd_t  crmd;
        bus32_t prmd;
        bus32_t ecfg;
        estat_t estat;
        bus32_t era;
        bus32_t badv;
        bus32_t eentry;
    } except_view_t;

    typedef struct packed {
        bus32_t tid;
        tcfg_t  tcfg;
        bus32_t tval;
    } timer_view_t;

endpackage

//--- csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Exception state
`define CSR_CRMD        14'h0
`define CSR_PRMD        14'h1
`define CSR_ECFG        14'h4
`define CSR_ESTAT       14'h5
`define CSR_ERA         14'h6
`define CSR_BADV        14'h7
`define CSR_EENTRY      14'hc

// Scratch
`define CSR_SAVE0       14'h30
`define CSR_SAVE1       14'h31
`define CSR_SAVE2       14'h32
`define CSR_SAVE3       14'h33

// Timer
`define CSR_TID         14'h40
`define CSR_TCFG        14'h41
`define CSR_TVAL        14'h42
`define CSR_TICLR       14'h44

// Ecodes that touch BADV or CRMD
`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ECODE_TLBR      6'h3f

// Software-writable bits
`define CRMD_WMASK      32'h0000_01ff   // DATM, DATF, PG, DA, IE, PLV
`define PRMD_WMASK      32'h0000_0007   // PIE, PPLV
`define ECFG_WMASK      32'h0000_1bff   // LIE 12:11 and 9:0
`define ESTAT_WMASK     32'h0000_0003   // Software interrupt bits only
`define EENTRY_WMASK    32'hffff_ffc0   // 64-byte aligned entry

`define CRMD_RESET      32'h0000_0008   // DA on
`define TVAL_RESET      32'hffff_ffff

`endif
